/* Bender.yml */
package:
  name: vertex_stream

export_include_dirs:
  - rtl

sources:
  - rtl/graph_stream_pkg.sv
  - rtl/mixed_width_ram.sv
  - rtl/cacheline_stream.sv
  - rtl/vertex_assembler.sv
  - rtl/vertex_stream_top.sv
  - target: test
    files:
      - verif/vertex_stream_tb.sv

/* rtl/cacheline_stream.sv */
// One line in flight; responses cannot be stalled and offset plus count must fit the line
`timescale 1ns/1ps
`include "graph_stream_params.svh"

module cacheline_stream import graph_stream_pkg::*; #(
	parameter type word_t = degree_t,
	parameter logic [`GS_TAG_BITS-1:0] MATCH_TAG = `GS_TAG_DEGREE
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  logic           start,
	input  logic           clear,
	input  read_response_t resp_half0,
	input  read_response_t resp_half1,
	output word_t          word,
	output logic           word_valid,
	output logic           pending
);

	localparam int WORD_BITS = $bits(word_t);
	localparam int WORD_BYTES = WORD_BITS / 8;
	localparam int WORDS = `GS_LINE_BITS / WORD_BITS;
	localparam int ADDR_BITS = $clog2(WORDS);

	// Response latch
	logic                     hit0;
	logic                     hit1;
	logic                     lat_valid;
	logic                     lat_half;
	read_cmd_t                lat_cmd;
	logic [`GS_HALF_BITS-1:0] lat_data;

	// Stream state
	logic [1:0]                arrival;
	logic [`GS_COUNT_BITS-1:0] issued;
	logic [`GS_COUNT_BITS-1:0] count_lim;
	logic [ADDR_BITS-1:0]      rd_addr;
	logic                      go;
	logic                      rd_fire;
	logic                      last_rd;
	word_t                     ram_word;

	// ------------------------------------------------------------------------
	// Capture halves tagged for this structure
	// ------------------------------------------------------------------------

	assign hit0 = resp_half0.valid && (resp_half0.cmd.structure == MATCH_TAG);
	assign hit1 = resp_half1.valid && (resp_half1.cmd.structure == MATCH_TAG);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lat_valid <= 1'b0;
		end else begin
			lat_valid <= enabled && (hit0 || hit1);
		end
	end

	// Half 0 wins if both channels show up together
	always_ff @(posedge clock) begin
		if (hit0) begin
			lat_cmd  <= resp_half0.cmd;
			lat_data <= resp_half0.data;
			lat_half <= 1'b0;
		end else if (hit1) begin
			lat_cmd  <= resp_half1.cmd;
			lat_data <= resp_half1.data;
			lat_half <= 1'b1;
		end
	end

	mixed_width_ram #(
		.word_t(word_t)
	) u_ram (
		.clock   (clock),
		.we      (lat_valid),
		.wr_addr (lat_half),
		.data_in (lat_data),
		.rd_addr (rd_addr),
		.data_out(ram_word)
	);

	// ------------------------------------------------------------------------
	// Read back one word per cycle from the offset
	// ------------------------------------------------------------------------

	assign go      = start && enabled && pending;
	assign rd_fire = go && (issued < count_lim);
	// Also true at once for a zero count so the job still ends
	assign last_rd = go && (({1'b0, issued} + 7'd1) >= {1'b0, count_lim});

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			arrival    <= 2'b00;
			pending    <= 1'b0;
			issued     <= '0;
			count_lim  <= '0;
			rd_addr    <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= rd_fire;
			if (clear || !enabled) begin
				arrival   <= 2'b00;
				pending   <= 1'b0;
				issued    <= '0;
				count_lim <= '0;
				rd_addr   <= '0;
			end else if (lat_valid) begin
				issued    <= '0;
				count_lim <= lat_cmd.count;
				rd_addr   <= lat_cmd.offset[ADDR_BITS-1:0];
				// Line is complete once both halves are in the RAM
				if ((arrival | (2'b01 << lat_half)) == 2'b11) begin
					arrival <= 2'b00;
					pending <= 1'b1;
				end else begin
					arrival <= arrival | (2'b01 << lat_half);
				end
			end else begin
				if (rd_fire) begin
					issued  <= issued + 1'b1;
					rd_addr <= rd_addr + 1'b1;
				end
				if (last_rd) begin
					pending <= 1'b0;
				end
			end
		end
	end

	// Line bytes are big-endian, so flip each word
	always_comb begin
		logic [WORD_BITS-1:0] raw;
		logic [WORD_BITS-1:0] swapped;
		raw = ram_word;
		for (int i = 0; i < WORD_BYTES; i++) begin
			swapped[8*i +: 8] = raw[8*(WORD_BYTES-1-i) +: 8];
		end
		word = word_t'(swapped);
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------

	a_one_channel: assert property (@(posedge clock) disable iff (!rstn)
		!(resp_half0.valid && resp_half1.valid))
		else $error("both response channels valid together, half 1 lost");

	a_fits_line: assert property (@(posedge clock) disable iff (!rstn)
		lat_valid |-> (int'(lat_cmd.offset) + int'(lat_cmd.count)) <= WORDS)
		else $error("offset %0d plus count %0d overruns the line", lat_cmd.offset, lat_cmd.count);

	a_word_after_start: assert property (@(posedge clock) disable iff (!rstn)
		word_valid |-> $past(start))
		else $error("word_valid without start in the previous cycle");

endmodule

/* rtl/graph_stream_params.svh */
// Widths assume a 512-bit line split in two 256-bit halves and at most 32 words per line
`ifndef GRAPH_STREAM_PARAMS_SVH
`define GRAPH_STREAM_PARAMS_SVH

// ----------------------------------------------------------------------------
// Line geometry
// ----------------------------------------------------------------------------

// One response channel carries half of a cache line
`define GS_HALF_BITS 256
`define GS_LINE_BITS (2 * `GS_HALF_BITS)

// Offset and count of a command, wide enough to hold 32
`define GS_COUNT_BITS 6

// ----------------------------------------------------------------------------
// Structure tags
// ----------------------------------------------------------------------------

`define GS_TAG_BITS 2

// Tag 0 is unused and tag 3 belongs to other structures
`define GS_TAG_DEGREE   2'd1
`define GS_TAG_EDGE_IDX 2'd2

`endif

/* rtl/graph_stream_pkg.sv */
// Shared word and bus types; field order sets the bit layout seen by the testbench
`include "graph_stream_params.svh"

package graph_stream_pkg;

	// Payload words sliced out of a line
	typedef logic [15:0] degree_t;
	typedef logic [31:0] edge_idx_t;

	// ------------------------------------------------------------------------
	// Memory response channel
	// ------------------------------------------------------------------------

	// Command tag echoed with each half of a line, 14 bits
	typedef struct packed {
		logic [`GS_TAG_BITS-1:0]   structure;
		logic [`GS_COUNT_BITS-1:0] offset;
		logic [`GS_COUNT_BITS-1:0] count;
	} read_cmd_t;

	// One half-line response, 271 bits
	typedef struct packed {
		logic                     valid;
		read_cmd_t                cmd;
		logic [`GS_HALF_BITS-1:0] data;
	} read_response_t;

	// ------------------------------------------------------------------------
	// Output record
	// ------------------------------------------------------------------------

	// 50 bits, last marks the final pair of a job
	typedef struct packed {
		logic      valid;
		logic      last;
		degree_t   degree;
		edge_idx_t edge_idx;
	} vertex_record_t;

endpackage

/* rtl/mixed_width_ram.sv */
// Word 0 of each half sits at its most significant end; read-during-write returns old data
`timescale 1ns/1ps
`include "graph_stream_params.svh"

module mixed_width_ram import graph_stream_pkg::*; #(
	parameter type word_t = edge_idx_t,
	localparam int WORD_BITS = $bits(word_t),
	localparam int WORDS_PER_HALF = `GS_HALF_BITS / WORD_BITS,
	localparam int RD_ADDR_BITS = $clog2(2 * WORDS_PER_HALF)
) (
	input  logic                     clock,
	input  logic                     we,
	input  logic                     wr_addr,
	input  logic [`GS_HALF_BITS-1:0] data_in,
	input  logic [RD_ADDR_BITS-1:0]  rd_addr,
	output word_t                    data_out
);

	logic [`GS_HALF_BITS-1:0] mem [2];

	// Upper address bit picks the half, the rest picks the word inside it
	logic                    rd_half;
	logic [RD_ADDR_BITS-2:0] rd_pos;
	int unsigned             rd_top;

	assign rd_half = rd_addr[RD_ADDR_BITS-1];
	assign rd_pos  = rd_addr[RD_ADDR_BITS-2:0];
	assign rd_top  = `GS_HALF_BITS - 1 - rd_pos * WORD_BITS;

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= data_in;
		end
		data_out <= word_t'(mem[rd_half][rd_top -: WORD_BITS]);
	end

	// Words must tile a half-line with nothing left over
	a_word_fits: assert property (@(posedge clock) (`GS_HALF_BITS % WORD_BITS) == 0)
		else $error("word width %0d does not divide a half-line", WORD_BITS);

endmodule

/* rtl/vertex_assembler.sv */
// Both streams must start in the same cycle; records are never stalled
`timescale 1ns/1ps

module vertex_assembler import graph_stream_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  logic           degree_pending,
	input  logic           edge_pending,
	input  degree_t        degree_word,
	input  logic           degree_valid,
	input  edge_idx_t      edge_word,
	input  logic           edge_valid,
	output logic           start,
	output logic           clear,
	output vertex_record_t record
);

	logic      both_pending;
	logic      both_pending_q;
	logic      rec_valid;
	logic      rec_last;
	degree_t   rec_degree;
	edge_idx_t rec_edge;

	// ------------------------------------------------------------------------
	// Job control
	// ------------------------------------------------------------------------

	assign both_pending = degree_pending && edge_pending;

	// First pending to fall ends the job for both units
	assign clear = both_pending_q && !both_pending;
	assign start = enabled && both_pending && !clear;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			both_pending_q <= 1'b0;
		end else begin
			both_pending_q <= both_pending;
		end
	end

	// ------------------------------------------------------------------------
	// Record packing
	// ------------------------------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rec_valid <= 1'b0;
			rec_last  <= 1'b0;
		end else begin
			rec_valid <= degree_valid && edge_valid;
			// A pair seen after a pending fell came from the final read
			rec_last  <= degree_valid && edge_valid && !both_pending;
		end
	end

	always_ff @(posedge clock) begin
		rec_degree <= degree_word;
		rec_edge   <= edge_word;
	end

	assign record = '{
		valid:    rec_valid,
		last:     rec_last,
		degree:   rec_degree,
		edge_idx: rec_edge
	};

	// Streams read in lockstep so their words arrive together
	a_aligned: assert property (@(posedge clock) disable iff (!rstn)
		degree_valid == edge_valid)
		else $error("degree and edge words out of step");

endmodule

/* rtl/vertex_stream_top.sv */
// Expects valid-only responses with one line per structure in flight
`timescale 1ns/1ps
`include "graph_stream_params.svh"

module vertex_stream_top import graph_stream_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  read_response_t resp_half0,
	input  read_response_t resp_half1,
	output vertex_record_t record
);

	degree_t   degree_word;
	logic      degree_valid;
	logic      degree_pending;
	edge_idx_t edge_word;
	logic      edge_valid;
	logic      edge_pending;
	logic      start;
	logic      clear;

	// 16-bit out-degree words
	cacheline_stream #(
		.word_t   (degree_t),
		.MATCH_TAG(`GS_TAG_DEGREE)
	) u_degree_stream (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.start     (start),
		.clear     (clear),
		.resp_half0(resp_half0),
		.resp_half1(resp_half1),
		.word      (degree_word),
		.word_valid(degree_valid),
		.pending   (degree_pending)
	);

	// 32-bit edge-index words
	cacheline_stream #(
		.word_t   (edge_idx_t),
		.MATCH_TAG(`GS_TAG_EDGE_IDX)
	) u_edge_stream (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.start     (start),
		.clear     (clear),
		.resp_half0(resp_half0),
		.resp_half1(resp_half1),
		.word      (edge_word),
		.word_valid(edge_valid),
		.pending   (edge_pending)
	);

	vertex_assembler u_assembler (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.degree_pending(degree_pending),
		.edge_pending  (edge_pending),
		.degree_word   (degree_word),
		.degree_valid  (degree_valid),
		.edge_word     (edge_word),
		.edge_valid    (edge_valid),
		.start         (start),
		.clear         (clear),
		.record        (record)
	);

endmodule

/* verif/vertex_stream_tb.sv */
// Runs from the project root; in every test all records must come after the last response line
`timescale 1ns/1ps
`include "graph_stream_params.svh"

module vertex_stream_tb import graph_stream_pkg::*; ();

	logic           clock;
	logic           rstn;
	logic           enabled;
	read_response_t resp_half0;
	read_response_t resp_half1;
	vertex_record_t record;

	vertex_record_t got_q[$];
	vertex_record_t exp_q[$];
	int             errors;
	int             checked;
	int             trace_lines;
	int             fd;
	string          cur_test;

	vertex_stream_top u_dut (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.resp_half0(resp_half0),
		.resp_half1(resp_half1),
		.record    (record)
	);

	always #10 clock = ~clock;

	// Records change on the rising edge, so take them on the falling one
	always @(negedge clock) begin
		if (rstn && record.valid) begin
			got_q.push_back(record);
		end
	end

	// Trace length is known before reset is released
	initial begin : watchdog
		@(posedge rstn);
		repeat (40 * trace_lines + 200) @(posedge clock);
		$display("ERROR: watchdog expired after %0d cycles", 40 * trace_lines + 200);
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Stimulus and checking
	// ------------------------------------------------------------------------

	// One half-line on one channel for one cycle
	task automatic send_half(input int half, input int tag, input int offset, input int count,
			input logic [`GS_HALF_BITS-1:0] data);
		read_response_t resp;
		if (got_q.size() != 0) begin
			$display("ERROR: test %s: a record arrived before all responses were sent", cur_test);
			errors++;
		end
		resp.valid         = 1'b1;
		resp.cmd.structure = `GS_TAG_BITS'(tag);
		resp.cmd.offset    = `GS_COUNT_BITS'(offset);
		resp.cmd.count     = `GS_COUNT_BITS'(count);
		resp.data          = data;
		enabled = 1'b1;
		if (half == 0) begin
			resp_half0 = resp;
		end else begin
			resp_half1 = resp;
		end
		@(posedge clock);
		#2;
		resp_half0 = '0;
		resp_half1 = '0;
	endtask

	task automatic hold_idle(input int cycles, input int en);
		enabled = en[0];
		repeat (cycles) begin
			@(posedge clock);
			#2;
		end
		enabled = 1'b1;
	endtask

	task automatic check_test();
		int             waited;
		int             n;
		int             i;
		vertex_record_t exp_rec;
		vertex_record_t got_rec;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < 150) begin
			@(posedge clock);
			#2;
			waited++;
		end
		// Room for a stray record behind the last one
		repeat (12) begin
			@(posedge clock);
			#2;
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (i = 0; i < n; i++) begin
			exp_rec = exp_q[i];
			got_rec = got_q[i];
			if (got_rec.degree !== exp_rec.degree) begin
				$display("MISMATCH %s record %0d degree: expected %h, actual %h",
					cur_test, i, exp_rec.degree, got_rec.degree);
				errors++;
			end
			if (got_rec.edge_idx !== exp_rec.edge_idx) begin
				$display("MISMATCH %s record %0d edge_idx: expected %h, actual %h",
					cur_test, i, exp_rec.edge_idx, got_rec.edge_idx);
				errors++;
			end
			if (got_rec.last !== exp_rec.last) begin
				$display("MISMATCH %s record %0d last: expected %b, actual %b",
					cur_test, i, exp_rec.last, got_rec.last);
				errors++;
			end
			checked++;
		end
		if (got_q.size() < exp_q.size()) begin
			$display("ERROR: test %s: %0d expected records never arrived",
				cur_test, exp_q.size() - got_q.size());
			errors++;
		end
		if (got_q.size() > exp_q.size()) begin
			$display("ERROR: test %s: %0d records arrived that were not expected",
				cur_test, got_q.size() - exp_q.size());
			errors++;
		end
		got_q.delete();
		exp_q.delete();
	endtask

	initial begin : main_flow
		string                    name;
		string                    kind;
		string                    rest;
		int                       half;
		int                       tag;
		int                       offset;
		int                       count;
		int                       cycles;
		int                       en;
		int                       last_bit;
		int                       n_read;
		logic [`GS_HALF_BITS-1:0] data;
		logic [15:0]              exp_degree;
		logic [31:0]              exp_edge;
		vertex_record_t           rec;
		clock       = 1'b0;
		rstn        = 1'b0;
		enabled     = 1'b0;
		resp_half0  = '0;
		resp_half1  = '0;
		errors      = 0;
		checked     = 0;
		trace_lines = 0;
		cur_test    = "";
		fd = $fopen("verif/vertex_stream_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open verif/vertex_stream_trace.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(rest, fd) != 0) begin
					trace_lines++;
				end
			end
			$fclose(fd);
			fd = $fopen("verif/vertex_stream_trace.txt", "r");
		end
		repeat (4) @(posedge clock);
		#2;
		rstn    = 1'b1;
		enabled = 1'b1;
		@(posedge clock);
		#2;
		if (fd != 0) begin
			while ($fscanf(fd, "%s", name) == 1) begin
				if (name[0] == "#") begin
					n_read = $fgets(rest, fd);
				end else begin
					n_read = $fscanf(fd, "%s", kind);
					if (name != cur_test) begin
						if (cur_test != "") begin
							check_test();
						end
						cur_test = name;
					end
					if (kind == "R") begin
						n_read = $fscanf(fd, "%d %d %d %d %h", half, tag, offset, count, data);
						if (n_read != 5) begin
							$display("ERROR: test %s: a response line could not be read", name);
							errors++;
						end else begin
							send_half(half, tag, offset, count, data);
						end
					end else if (kind == "E") begin
						n_read = $fscanf(fd, "%h %h %d", exp_degree, exp_edge, last_bit);
						if (n_read != 3) begin
							$display("ERROR: test %s: an expected record line could not be read",
								name);
							errors++;
						end else begin
							rec = '{valid: 1'b1, last: last_bit[0], degree: exp_degree,
								edge_idx: exp_edge};
							exp_q.push_back(rec);
						end
					end else if (kind == "I") begin
						n_read = $fscanf(fd, "%d %d", cycles, en);
						if (n_read != 2) begin
							$display("ERROR: test %s: an idle line could not be read", name);
							errors++;
						end else begin
							hold_idle(cycles, en);
						end
					end else begin
						$display("ERROR: unknown line kind %s in test %s", kind, name);
						errors++;
					end
				end
			end
			if (cur_test != "") begin
				check_test();
			end
			$fclose(fd);
		end
		$display("Checked %0d records, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* verif/vertex_stream_trace.txt */
# name R half tag offset count data (hex, word 0 at the left)
# name E degree edge_idx last | name I cycles enabled
full R 0 1 0 32 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
full R 1 1 0 32 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
full R 0 2 0 16 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
full R 1 2 0 16 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
full E 4000 302010C0 0
full E 4101 312111C1 0
full E 4202 322212C2 0
full E 4303 332313C3 0
full E 4404 342414C4 0
full E 4505 352515C5 0
full E 4606 362616C6 0
full E 4707 372717C7 0
full E 4808 382818C8 0
full E 4909 392919C9 0
full E 4A0A 3A2A1ACA 0
full E 4B0B 3B2B1BCB 0
full E 4C0C 3C2C1CCC 0
full E 4D0D 3D2D1DCD 0
full E 4E0E 3E2E1ECE 0
full E 4F0F 3F2F1FCF 1
offsets R 0 1 5 4 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
offsets R 1 1 5 4 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
offsets R 0 2 3 4 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
offsets R 1 2 3 4 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
offsets E 5515 3B2B1BCB 0
offsets E 5616 3C2C1CCC 0
offsets E 5717 3D2D1DCD 0
offsets E 5818 3E2E1ECE 1
unequal R 1 1 14 3 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
unequal R 0 1 14 3 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
unequal R 0 2 0 7 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
unequal R 1 2 0 7 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
unequal E 4E0E 302010C0 0
unequal E 4F0F 312111C1 0
unequal E 5010 322212C2 1
foreign R 0 1 0 2 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
foreign R 1 3 0 0 DEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEF
foreign R 1 1 0 2 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
foreign R 0 2 9 2 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
foreign R 0 3 0 0 DEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEFDEADBEEF
foreign I 6 1
foreign R 1 2 9 2 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
foreign E 5010 312111C1 0
foreign E 5111 322212C2 1
enable R 0 1 2 2 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
enable R 1 1 2 2 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
enable R 0 2 2 2 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
enable R 1 2 2 2 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
enable I 1 1
enable I 6 0
enable R 0 1 30 2 10501151125213531454155516561757185819591A5A1B5B1C5C1D5D1E5E1F5F
enable R 1 1 30 2 00400141024203430444054506460747084809490A4A0B4B0C4C0D4D0E4E0F4F
enable R 0 2 14 2 C8182838C9192939CA1A2A3ACB1B2B3BCC1C2C3CCD1D2D3DCE1E2E3ECF1F2F3F
enable R 1 2 14 2 C0102030C1112131C2122232C3132333C4142434C5152535C6162636C7172737
enable E 4E0E 362616C6 0
enable E 4F0F 372717C7 1

/* vlog.f */
+incdir+rtl
rtl/graph_stream_pkg.sv
rtl/mixed_width_ram.sv
rtl/cacheline_stream.sv
rtl/vertex_assembler.sv
rtl/vertex_stream_top.sv
verif/vertex_stream_tb.sv
